//--- ex_alu.sv
/*
 * Purely combinational, results are valid in the cycle of the inputs.
 * Shifts use the low 5 bits of B; compares give 0 or 1 on result_o.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_alu (
  input  wire ex_pkg::alu_opcode_e op_i,
  input  wire ex_pkg::word_t       operand_a_i,
  input  wire ex_pkg::word_t       operand_b_i,
  output ex_pkg::word_t            result_o,
  output logic                     cmp_result_o
);

  // Reverse bit order, lets the right shifter also do left shifts
  function automatic ex_pkg::word_t bit_rev(input ex_pkg::word_t w);
    ex_pkg::word_t r;
    for (int i = 0; i < `EX_XLEN; i++) begin
      r[i] = w[`EX_XLEN-1-i];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  logic          is_sub;
  ex_pkg::word_t adder_b;
  ex_pkg::word_t adder_sum;

  // Subtract as A + ~B + 1
  assign is_sub    = (op_i == ex_pkg::ALU_SUB);
  assign adder_b   = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = operand_a_i + adder_b + ex_pkg::word_t'(is_sub);

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  logic                         shift_left;
  logic                         shift_arith;
  logic [`EX_SHAMT_W-1:0]       shamt;
  ex_pkg::word_t                shift_in;
  logic signed [`EX_XLEN:0]     shift_ext;
  ex_pkg::word_t                shift_right;

  assign shift_left  = (op_i == ex_pkg::ALU_SLL);
  assign shift_arith = (op_i == ex_pkg::ALU_SRA);
  assign shamt       = operand_b_i[`EX_SHAMT_W-1:0];

  // Left shift is a right shift of the reversed word
  assign shift_in    = shift_left ? bit_rev(operand_a_i) : operand_a_i;
  // Extra top bit carries the sign only for SRA
  assign shift_ext   = $signed({shift_arith & shift_in[`EX_XLEN-1], shift_in}) >>> shamt;
  assign shift_right = shift_ext[`EX_XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_less;
  logic is_branch;
  logic cmp;

  assign cmp_signed = (op_i == ex_pkg::ALU_SLT) || (op_i == ex_pkg::ALU_LT) ||
                      (op_i == ex_pkg::ALU_GE);
  assign is_equal   = (operand_a_i == operand_b_i);
  assign is_less    = cmp_signed ? ($signed(operand_a_i) < $signed(operand_b_i))
                                 : (operand_a_i < operand_b_i);

  // Branch codes sit in the upper block of the encoding
  assign is_branch  = (op_i >= ex_pkg::ALU_EQ);

  always_comb begin
    unique case (op_i)
      ex_pkg::ALU_EQ:                   cmp = is_equal;
      ex_pkg::ALU_NE:                   cmp = ~is_equal;
      ex_pkg::ALU_GE, ex_pkg::ALU_GEU:  cmp = ~is_less;
      // SLT, SLTU, LT, LTU
      default:                          cmp = is_less;
    endcase
  end

  assign cmp_result_o = is_branch & cmp;

  // Result select
  always_comb begin
    unique case (op_i)
      ex_pkg::ALU_ADD, ex_pkg::ALU_SUB: result_o = adder_sum;
      ex_pkg::ALU_AND:                  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:                   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:                  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:                  result_o = bit_rev(shift_right);
      ex_pkg::ALU_SRL, ex_pkg::ALU_SRA: result_o = shift_right;
      // Set-less-than and branch compares
      default:                          result_o = ex_pkg::word_t'(cmp);
    endcase
  end

endmodule

`default_nettype wire

//--- ex_consts.svh
/*
 * Widths are fixed by the 32-bit instruction set and are not meant to be overridden.
 * EX_MULH_CYCLES must divide EX_XLEN evenly, since MULH takes one slice of B per cycle.
 */

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data word width
`define EX_XLEN 32

// Register file address width, covers integer and extra registers
`define EX_RF_AW 6

// Operation field width from decode
`define EX_OP_W 4

// Shift amount width, the low bits of operand B
`define EX_SHAMT_W 5

// Busy cycles of MULH after acceptance
`define EX_MULH_CYCLES 4

// Bits of operand B consumed per MULH cycle
`define EX_MULH_SLICE (`EX_XLEN / `EX_MULH_CYCLES)

`endif

//--- ex_mult.sv
/*
 * MUL is combinational; MULH is signed x signed and is busy for EX_MULH_CYCLES cycles.
 * The MULH result is held with ready_o high until ex_ready_i is seen.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_mult (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                enable_i,
  input  wire ex_pkg::mul_opcode_e op_i,
  input  wire ex_pkg::word_t       operand_a_i,
  input  wire ex_pkg::word_t       operand_b_i,
  input  wire logic                ex_ready_i,
  output ex_pkg::word_t            result_o,
  output logic                     ready_o,
  output logic                     multicycle_o
);

  localparam int unsigned CNT_W = $clog2(`EX_MULH_CYCLES);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EX_MULH_CYCLES - 1);

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_BUSY,
    MULT_DONE
  } mult_state_e;

  mult_state_e                   state_q, state_d;
  logic [CNT_W-1:0]              cnt_q;
  logic                          mulh_start;

  // Operand and accumulator payload
  ex_pkg::word_t                 op_a_q;
  ex_pkg::word_t                 op_b_q;
  logic signed [2*`EX_XLEN-1:0]  acc_q;

  logic [`EX_MULH_SLICE-1:0]     slice;
  logic signed [`EX_MULH_SLICE:0] slice_ext;
  logic signed [2*`EX_XLEN-1:0]  pp;
  logic [2*`EX_XLEN-1:0]         mul_full;

  ////////////////////////////////////////////////////////////
  // Single-cycle MUL
  ////////////////////////////////////////////////////////////

  // Low word is the same for signed and unsigned operands
  assign mul_full = operand_a_i * operand_b_i;

  ////////////////////////////////////////////////////////////
  // Iterative MULH
  ////////////////////////////////////////////////////////////

  assign mulh_start = enable_i && (op_i == ex_pkg::MUL_H) && (state_q == MULT_IDLE);

  // One slice of B per busy cycle starting at the LSB
  assign slice     = op_b_q[cnt_q*`EX_MULH_SLICE +: `EX_MULH_SLICE];
  // Only the top slice carries the sign of B
  assign slice_ext = $signed({(cnt_q == CNT_LAST) & slice[`EX_MULH_SLICE-1], slice});
  assign pp        = ($signed(op_a_q) * slice_ext) <<< (cnt_q * `EX_MULH_SLICE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULT_IDLE: if (mulh_start) state_d = MULT_BUSY;
      MULT_BUSY: if (cnt_q == CNT_LAST) state_d = MULT_DONE;
      // Hold result until the stage moves on
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MULT_BUSY) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  // Capture on accept and accumulate while busy
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      op_a_q <= operand_a_i;
      op_b_q <= operand_b_i;
      acc_q  <= '0;
    end else if (state_q == MULT_BUSY) begin
      acc_q  <= acc_q + pp;
    end
  end

  // Accept cycle and busy cycles stall the stage
  assign ready_o      = !(mulh_start || (state_q == MULT_BUSY));
  assign multicycle_o = (state_q == MULT_BUSY);
  assign result_o     = (state_q == MULT_DONE) ? acc_q[2*`EX_XLEN-1:`EX_XLEN]
                                               : mul_full[`EX_XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Accepted MULH is busy for exactly EX_MULH_CYCLES and ready with the result after that
  a_mulh_latency: assert property (@(posedge clk) disable iff (!rst_n)
    mulh_start |=> (!ready_o && multicycle_o) [*`EX_MULH_CYCLES] ##1 ready_o)
    else $error("MULH busy window has wrong length");

  // Stalled decode keeps presenting the captured operands while busy
  a_mulh_operands: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MULT_BUSY) |-> ((operand_a_i == op_a_q) && (operand_b_i == op_b_q)))
    else $error("MULH operands changed while busy");

endmodule

`default_nettype wire

//--- ex_pkg.sv
/*
 * Shared types of the execute stage.
 * One operation field feeds both units, read through ex_op_u.
 */

`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

  // Data word and register file address
  typedef logic [`EX_XLEN-1:0]  word_t;
  typedef logic [`EX_RF_AW-1:0] rf_addr_t;

  // ALU and branch operations, all 16 codes in use
  typedef enum logic [`EX_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch compares
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_opcode_e;

  // Multiplier operations
  typedef enum logic [`EX_OP_W-1:0] {
    MUL_L = 4'h0,  // low word, single cycle
    MUL_H = 4'h1   // signed high word, iterative
  } mul_opcode_e;

  // Decode operation field, ALU view when alu_en_i, multiplier view when mult_en_i
  typedef union packed {
    alu_opcode_e alu;
    mul_opcode_e mul;
  } ex_op_u;

endpackage

`default_nettype wire

//--- ex_stage.sv
/*
 * Reduced execute stage: ALU, multiplier, CSR select and EX/WB load register.
 * Forwarding data priority is CSR, then multiplier, then ALU.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage (
  input  wire logic             clk,
  input  wire logic             rst_n,

  // Unit enables from decode
  input  wire logic             alu_en_i,
  input  wire logic             mult_en_i,
  input  wire logic             csr_access_i,
  input  wire logic             lsu_en_i,
  input  wire ex_pkg::ex_op_u   op_i,

  // Operands, shared by ALU and multiplier
  input  wire ex_pkg::word_t    operand_a_i,
  input  wire ex_pkg::word_t    operand_b_i,
  input  wire ex_pkg::word_t    operand_c_i,
  input  wire ex_pkg::word_t    csr_rdata_i,
  input  wire ex_pkg::word_t    lsu_rdata_i,

  // Forwarding write port request
  input  wire logic             regfile_alu_we_i,
  input  wire ex_pkg::rf_addr_t regfile_alu_waddr_i,

  // Load write port request, passed to WB
  input  wire logic             regfile_we_i,
  input  wire ex_pkg::rf_addr_t regfile_waddr_i,

  // Stall control
  input  wire logic             lsu_ready_ex_i,
  input  wire logic             lsu_err_i,
  input  wire logic             branch_in_ex_i,
  input  wire logic             wb_ready_i,

  // Forwarding port to ID and register file
  output logic                  regfile_alu_we_fw_o,
  output ex_pkg::rf_addr_t      regfile_alu_waddr_fw_o,
  output ex_pkg::word_t         regfile_alu_wdata_fw_o,

  // Load write-back port
  output logic                  regfile_we_wb_o,
  output ex_pkg::rf_addr_t      regfile_waddr_wb_o,
  output ex_pkg::word_t         regfile_wdata_wb_o,

  // Branch outcome to IF
  output ex_pkg::word_t         jump_target_o,
  output logic                  branch_decision_o,

  // Handshake
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  mult_multicycle_o
);

  ex_pkg::word_t    alu_result;
  logic             alu_cmp_result;
  ex_pkg::word_t    mult_result;
  logic             mult_ready;
  logic             wb_we;
  ex_pkg::rf_addr_t wb_waddr;
  logic             units_ready;

  ////////////////////////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////////////////////////

  // Same operation field, decoded per unit
  ex_alu u_alu (
    .op_i         (op_i.alu),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .op_i         (op_i.mul),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////

  // Forwarding port, enable and address straight from decode
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result;
    end else begin
      regfile_alu_wdata_fw_o = alu_result;
    end
  end

  // Load port, data arrives live from the LSU one cycle after EX
  ex_wb_reg u_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_err_i       (lsu_err_i),
    .we_o            (wb_we),
    .waddr_o         (wb_waddr)
  );

  assign regfile_we_wb_o    = wb_we;
  assign regfile_waddr_wb_o = wb_waddr;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branch target is computed in ID and passed on operand C
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = operand_c_i;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid goes forward without looking at ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

//--- ex_wb_reg.sv
/*
 * Holds the pending load write-back; a load error squashes the write.
 * Contents hold while wb_ready_i is low.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_wb_reg (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             ex_valid_i,
  input  wire logic             wb_ready_i,
  input  wire logic             regfile_we_i,
  input  wire ex_pkg::rf_addr_t regfile_waddr_i,
  input  wire logic             lsu_err_i,
  output logic                  we_o,
  output ex_pkg::rf_addr_t      waddr_o
);

  logic load_we;

  // Write only loads that completed without error
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_o <= 1'b0;
    end else if (ex_valid_i) begin
      we_o <= load_we;
    end else if (wb_ready_i) begin
      // Nothing new for WB, flush the old write
      we_o <= 1'b0;
    end
  end

  // Address is only meaningful with the enable
  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      waddr_o <= regfile_waddr_i;
    end
  end

  // Stage never reports valid into a stalled WB
  a_valid_needs_wb_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else $error("EX valid while WB is not ready");

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_wb_reg.sv
ex_stage.sv
tb_ex_stage.sv

//--- tb_ex_stage.sv
/*
 * Directed testbench for ex_stage. Expected values come from an ISA-level model.
 * Inputs change on the rising edge and outputs are sampled on the falling edge.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module tb_ex_stage;

  localparam int N_ALU_OPS = 10;
  localparam int N_PAIRS   = 8;
  localparam int N_MULH    = 4;
  localparam int MULH_WAIT = 2 * `EX_MULH_CYCLES + 4;

  // Cycles per test for reset, alu, branch, mul, mulh, csr and load plus idle gaps
  localparam int TEST_CYCLES = 12 + N_ALU_OPS * N_PAIRS + 6 * N_PAIRS + N_PAIRS
                             + N_MULH * (`EX_MULH_CYCLES + 3) + 4 + 16 + 6 * 2;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             alu_en_i;
  logic             mult_en_i;
  logic             csr_access_i;
  logic             lsu_en_i;
  ex_pkg::ex_op_u   op_i;
  ex_pkg::word_t    operand_a_i;
  ex_pkg::word_t    operand_b_i;
  ex_pkg::word_t    operand_c_i;
  ex_pkg::word_t    csr_rdata_i;
  ex_pkg::word_t    lsu_rdata_i;
  logic             regfile_alu_we_i;
  ex_pkg::rf_addr_t regfile_alu_waddr_i;
  logic             regfile_we_i;
  ex_pkg::rf_addr_t regfile_waddr_i;
  logic             lsu_ready_ex_i;
  logic             lsu_err_i;
  logic             branch_in_ex_i;
  logic             wb_ready_i;

  logic             regfile_alu_we_fw_o;
  ex_pkg::rf_addr_t regfile_alu_waddr_fw_o;
  ex_pkg::word_t    regfile_alu_wdata_fw_o;
  logic             regfile_we_wb_o;
  ex_pkg::rf_addr_t regfile_waddr_wb_o;
  ex_pkg::word_t    regfile_wdata_wb_o;
  ex_pkg::word_t    jump_target_o;
  logic             branch_decision_o;
  logic             ex_ready_o;
  logic             ex_valid_o;
  logic             mult_multicycle_o;

  // Bookkeeping
  int               cycle_cnt  = 0;
  int               err_cnt    = 0;
  int               test_cnt   = 0;
  int               fail_tests = 0;
  string            cur_test   = "init";
  ex_pkg::word_t    rand_state = 32'h8eebca8b;

  ex_stage UUT (.*);

  always #10 clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout in test %s, run stopped after %0d cycles", cur_test, cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  function automatic ex_pkg::word_t next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_opcode_e op,
                                              input ex_pkg::word_t a, input ex_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << sh;
      ex_pkg::ALU_SRL:  return a >> sh;
      ex_pkg::ALU_SRA:  return $signed(a) >>> sh;
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:          return '0;
    endcase
  endfunction

  function automatic logic branch_model(input ex_pkg::alu_opcode_e op,
                                        input ex_pkg::word_t a, input ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  // Upper half of the signed 64-bit product
  function automatic ex_pkg::word_t mulh_model(input ex_pkg::word_t a, input ex_pkg::word_t b);
    longint sa;
    longint sb;
    longint p;
    sa = $signed(a);
    sb = $signed(b);
    p  = sa * sb;
    return p[63:32];
  endfunction

  function automatic ex_pkg::ex_op_u alu_op(input ex_pkg::alu_opcode_e op);
    ex_pkg::ex_op_u u;
    u.alu = op;
    return u;
  endfunction

  function automatic ex_pkg::ex_op_u mul_op(input ex_pkg::mul_opcode_e op);
    ex_pkg::ex_op_u u;
    u.mul = op;
    return u;
  endfunction

  task automatic check_word(input string label, input ex_pkg::word_t exp,
                            input ex_pkg::word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, label, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string label, input ex_pkg::rf_addr_t exp,
                            input ex_pkg::rf_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, label, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string label, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, label, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string label, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, label, exp, act);
      err_cnt++;
    end
  endtask

  task automatic end_test(input int errs0);
    test_cnt++;
    if (err_cnt == errs0) begin
      $display("test %s: ok", cur_test);
    end else begin
      fail_tests++;
      $display("test %s: %0d failed checks", cur_test, err_cnt - errs0);
    end
  endtask

  // All enables off and no back-pressure
  task automatic drive_idle();
    alu_en_i         <= 1'b0;
    mult_en_i        <= 1'b0;
    csr_access_i     <= 1'b0;
    lsu_en_i         <= 1'b0;
    regfile_alu_we_i <= 1'b0;
    regfile_we_i     <= 1'b0;
    lsu_err_i        <= 1'b0;
    branch_in_ex_i   <= 1'b0;
    lsu_ready_ex_i   <= 1'b1;
    wb_ready_i       <= 1'b1;
  endtask

  task automatic init_inputs();
    rst_n               <= 1'b0;
    op_i                <= '0;
    operand_a_i         <= '0;
    operand_b_i         <= '0;
    operand_c_i         <= '0;
    csr_rdata_i         <= '0;
    lsu_rdata_i         <= '0;
    regfile_alu_waddr_i <= '0;
    regfile_waddr_i     <= '0;
    drive_idle();
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int errs0;
    errs0    = err_cnt;
    cur_test = "reset";
    repeat (10) begin
      @(negedge clk);
      check_bit("we_wb in reset", 1'b0, regfile_we_wb_o);
      check_bit("multicycle in reset", 1'b0, mult_multicycle_o);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("we_wb after reset", 1'b0, regfile_we_wb_o);
    check_bit("multicycle after reset", 1'b0, mult_multicycle_o);
    // Idle multiplier leaves the stage ready
    check_bit("ready after reset", 1'b1, ex_ready_o);
    end_test(errs0);
  endtask

  task automatic test_alu();
    ex_pkg::alu_opcode_e op;
    ex_pkg::word_t       a;
    ex_pkg::word_t       b;
    ex_pkg::rf_addr_t    wa;
    logic                we;
    int                  errs0;
    errs0    = err_cnt;
    cur_test = "alu_ops";
    for (int i = 0; i < N_ALU_OPS; i++) begin
      op = ex_pkg::alu_opcode_e'(i);
      for (int j = 0; j < N_PAIRS; j++) begin
        a  = next_rand();
        b  = next_rand();
        wa = ex_pkg::rf_addr_t'(next_rand());
        // Forwarding enable alternates so both levels pass through
        we = (j % 2 == 1);
        @(posedge clk);
        alu_en_i            <= 1'b1;
        op_i                <= alu_op(op);
        operand_a_i         <= a;
        operand_b_i         <= b;
        regfile_alu_we_i    <= we;
        regfile_alu_waddr_i <= wa;
        @(negedge clk);
        check_word({op.name(), " data"}, alu_model(op, a, b), regfile_alu_wdata_fw_o);
        check_bit({op.name(), " valid"}, 1'b1, ex_valid_o);
        check_bit({op.name(), " fw we"}, we, regfile_alu_we_fw_o);
        check_addr({op.name(), " fw addr"}, wa, regfile_alu_waddr_fw_o);
      end
    end
    @(posedge clk);
    drive_idle();
    end_test(errs0);
  endtask

  task automatic test_branch();
    ex_pkg::alu_opcode_e op;
    ex_pkg::word_t       a;
    ex_pkg::word_t       b;
    ex_pkg::word_t       c;
    int                  errs0;
    errs0    = err_cnt;
    cur_test = "branches";
    for (int i = 0; i < 6; i++) begin
      op = ex_pkg::alu_opcode_e'(int'(ex_pkg::ALU_EQ) + i);
      for (int j = 0; j < N_PAIRS; j++) begin
        a = next_rand();
        b = next_rand();
        c = next_rand();
        // Equal pairs and then operands of opposite sign both ways round
        case (j)
          4, 5: b = a;
          6: begin
            a[`EX_XLEN-1] = 1'b1;
            b[`EX_XLEN-1] = 1'b0;
          end
          7: begin
            a[`EX_XLEN-1] = 1'b0;
            b[`EX_XLEN-1] = 1'b1;
          end
          default: ;
        endcase
        @(posedge clk);
        alu_en_i    <= 1'b1;
        op_i        <= alu_op(op);
        operand_a_i <= a;
        operand_b_i <= b;
        operand_c_i <= c;
        @(negedge clk);
        check_bit({op.name(), " decision"}, branch_model(op, a, b), branch_decision_o);
        check_word({op.name(), " target"}, c, jump_target_o);
      end
    end
    @(posedge clk);
    drive_idle();
    end_test(errs0);
  endtask

  task automatic test_mult();
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    int            busy;
    int            waited;
    logic          done;
    int            errs0;
    errs0    = err_cnt;
    cur_test = "multiply";
    for (int j = 0; j < N_PAIRS; j++) begin
      a = next_rand();
      b = next_rand();
      @(posedge clk);
      mult_en_i   <= 1'b1;
      op_i        <= mul_op(ex_pkg::MUL_L);
      operand_a_i <= a;
      operand_b_i <= b;
      @(negedge clk);
      check_word("mul low", a * b, regfile_alu_wdata_fw_o);
      check_bit("mul valid", 1'b1, ex_valid_o);
    end
    // First MULH pair squares the most negative value
    for (int j = 0; j < N_MULH; j++) begin
      a = (j == 0) ? 32'h8000_0000 : next_rand();
      b = (j == 0) ? 32'h8000_0000 : next_rand();
      @(posedge clk);
      mult_en_i   <= 1'b1;
      op_i        <= mul_op(ex_pkg::MUL_H);
      operand_a_i <= a;
      operand_b_i <= b;
      @(negedge clk);
      check_bit("mulh accept valid", 1'b0, ex_valid_o);
      busy   = 0;
      waited = 0;
      done   = 1'b0;
      while (!done && waited < MULH_WAIT) begin
        @(negedge clk);
        waited++;
        if (ex_valid_o) begin
          done = 1'b1;
        end else begin
          check_bit("mulh busy multicycle", 1'b1, mult_multicycle_o);
          busy++;
        end
      end
      if (!done) begin
        $display("ERROR %s: MULH result never became valid after %0d cycles", cur_test, waited);
        err_cnt++;
      end else begin
        check_count("mulh busy cycles", `EX_MULH_CYCLES, busy);
        check_word("mulh high", mulh_model(a, b), regfile_alu_wdata_fw_o);
        check_bit("mulh done multicycle", 1'b0, mult_multicycle_o);
      end
      @(posedge clk);
      mult_en_i <= 1'b0;
    end
    end_test(errs0);
  endtask

  task automatic test_csr();
    ex_pkg::word_t r;
    ex_pkg::word_t csr;
    int            errs0;
    errs0    = err_cnt;
    cur_test = "csr_priority";
    repeat (4) begin
      r   = next_rand();
      csr = next_rand();
      @(posedge clk);
      alu_en_i     <= 1'b1;
      csr_access_i <= 1'b1;
      op_i         <= alu_op(ex_pkg::alu_opcode_e'(r[3:0]));
      operand_a_i  <= next_rand();
      operand_b_i  <= next_rand();
      csr_rdata_i  <= csr;
      @(negedge clk);
      check_word("csr data", csr, regfile_alu_wdata_fw_o);
    end
    @(posedge clk);
    drive_idle();
    end_test(errs0);
  endtask

  task automatic test_load();
    ex_pkg::rf_addr_t addr;
    ex_pkg::word_t    data;
    int               errs0;
    errs0    = err_cnt;
    cur_test = "load_wb";
    addr     = ex_pkg::rf_addr_t'(next_rand());
    data     = next_rand();
    // Plain load writes back one cycle after the valid cycle
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= addr;
    @(negedge clk);
    check_bit("load valid", 1'b1, ex_valid_o);
    check_bit("no early write", 1'b0, regfile_we_wb_o);
    @(posedge clk);
    lsu_en_i     <= 1'b0;
    regfile_we_i <= 1'b0;
    lsu_rdata_i  <= data;
    @(negedge clk);
    check_bit("wb we", 1'b1, regfile_we_wb_o);
    check_addr("wb addr", addr, regfile_waddr_wb_o);
    check_word("wb data", data, regfile_wdata_wb_o);
    @(negedge clk);
    check_bit("flush", 1'b0, regfile_we_wb_o);

    // Load with bus error
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    lsu_err_i       <= 1'b1;
    regfile_waddr_i <= ~addr;
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_bit("error squash", 1'b0, regfile_we_wb_o);

    // WB stalls right after a load has been registered
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= addr;
    @(posedge clk);
    wb_ready_i      <= 1'b0;
    regfile_waddr_i <= ~addr;
    repeat (3) begin
      @(negedge clk);
      check_bit("stall valid", 1'b0, ex_valid_o);
      check_bit("stall ready", 1'b0, ex_ready_o);
      check_bit("stall we hold", 1'b1, regfile_we_wb_o);
      check_addr("stall addr hold", addr, regfile_waddr_wb_o);
    end
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    @(negedge clk);
    check_bit("branch ready", 1'b1, ex_ready_o);
    check_bit("branch valid", 1'b0, ex_valid_o);
    check_bit("branch we hold", 1'b1, regfile_we_wb_o);
    @(posedge clk);
    drive_idle();
    @(posedge clk);
    @(negedge clk);
    check_bit("release flush", 1'b0, regfile_we_wb_o);
    end_test(errs0);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    init_inputs();
    test_reset();
    test_alu();
    test_branch();
    test_mult();
    test_csr();
    test_load();
    $display("tests %0d, failed tests %0d, failed checks %0d", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
